// File: Bender.yml
package:
  name: openadc_supervisor

sources:
  - include_dirs:
      - design
    files:
      - design/openadc_pkg.sv
      - design/monitor_if.sv
      - design/gate_timer.sv
      - design/clk_monitor.sv
      - design/level_trigger.sv
      - design/led_indicator.sv
      - design/gain_pwm.sv
      - design/openadc_supervisor.sv

  - target: simulation
    include_dirs:
      - design
      - sim
    files:
      - sim/tb_openadc_supervisor.sv

// File: compile.f
+incdir+design
+incdir+sim
design/openadc_pkg.sv
design/monitor_if.sv
design/gate_timer.sv
design/clk_monitor.sv
design/level_trigger.sv
design/led_indicator.sv
design/gain_pwm.sv
design/openadc_supervisor.sv
sim/tb_openadc_supervisor.sv

// File: design/clk_monitor.sv
`timescale 1ns/1ns
`include "openadc_macros.svh"

module clk_monitor import openadc_pkg::*; #(
   parameter int gate_log2_p = `OADC_GATE_LOG2
) (
   input  logic  clk_usb,
   input  logic  reset,
   input  logic  ext_clk_i,
   input  logic  gate_pulse_i,
   input  logic  monitor_off_i,
   input  freq_t change_limit_i,
   monitor_if.monitor mon
);

   logic [2:0] ext_sync_q;  // two sync stages plus edge history
   logic tick_q;
   freq_t run_cnt_q;
   freq_t ext_freq_q;
   freq_t abs_diff;
   logic valid_q;
   logic changed_q;

   always_ff @(posedge clk_usb) begin
      if (reset) begin
         ext_sync_q <= '0;
         tick_q <= 1'b0;
      end else begin
         ext_sync_q <= {ext_sync_q[1:0], ext_clk_i};
         tick_q <= ext_sync_q[1] & ~ext_sync_q[2];
      end
   end

   assign abs_diff = (run_cnt_q > ext_freq_q) ? run_cnt_q - ext_freq_q
                                              : ext_freq_q - run_cnt_q;

   always_ff @(posedge clk_usb) begin
      if (reset) begin
         run_cnt_q <= '0;
         ext_freq_q <= '0;
         valid_q <= 1'b0;
      end else if (gate_pulse_i) begin
         ext_freq_q <= run_cnt_q;
         run_cnt_q <= freq_t'(tick_q);  // this tick belongs to the new window
         valid_q <= 1'b1;
      end else begin
         run_cnt_q <= run_cnt_q + freq_t'(tick_q);
      end
   end

   always_ff @(posedge clk_usb) begin
      if (reset)
         changed_q <= 1'b0;
      else if (monitor_off_i)
         changed_q <= 1'b0;
      else if (gate_pulse_i && ext_freq_q != '0 && abs_diff > change_limit_i)
         changed_q <= 1'b1;
   end

   assign mon.ext_freq = ext_freq_q;
   assign mon.freq_valid = valid_q;
   assign mon.clk_changed = changed_q;
   assign mon.ext_heartbeat = run_cnt_q[2];

   // flag has to stay down for as long as the monitor is disabled
   a_no_change_when_off: assert property (
      @(posedge clk_usb) disable iff (reset)
      monitor_off_i |=> !mon.clk_changed
   );

endmodule

// File: design/gain_pwm.sv
`timescale 1ns/1ns
`include "openadc_macros.svh"

module gain_pwm import openadc_pkg::*; (
   input  logic  clk_usb,
   input  logic  reset,
   input  gain_t gain_i,
   output logic  amp_gain_o
);

   logic [`OADC_GAIN_W:0] acc_q;  // msb is the carry

   always_ff @(posedge clk_usb) begin
      if (reset) begin
         acc_q <= '0;
         amp_gain_o <= 1'b0;
      end else begin
         acc_q <= {1'b0, acc_q[`OADC_GAIN_W-1:0]} + {1'b0, gain_i};
         amp_gain_o <= acc_q[`OADC_GAIN_W];
      end
   end

   a_zero_gain_low: assert property (
      @(posedge clk_usb) disable iff (reset)
      (gain_i == '0) [*2] |=> !amp_gain_o
   );

endmodule

// File: design/gate_timer.sv
`timescale 1ns/1ns
`include "openadc_macros.svh"

module gate_timer import openadc_pkg::*; #(
   parameter int gate_log2_p = `OADC_GATE_LOG2
) (
   input  logic clk_usb,
   input  logic reset,
   output logic gate_pulse_o,
   output logic heartbeat_o,
   output logic flash_o
);

   localparam int cnt_w = gate_log2_p + 3;

   logic [cnt_w-1:0] timer_q;
   logic gate_bit_q;

   always_ff @(posedge clk_usb) begin
      if (reset) begin
         timer_q <= '0;
         gate_bit_q <= 1'b0;
         gate_pulse_o <= 1'b0;
      end else begin
         timer_q <= timer_q + 1'b1;
         gate_bit_q <= timer_q[gate_log2_p-1];
         // one cycle per rising edge of the gate bit
         gate_pulse_o <= timer_q[gate_log2_p-1] & ~gate_bit_q;
      end
   end

   // flash toggles only in the upper half of the top period
   always_ff @(posedge clk_usb) begin
      if (reset)
         flash_o <= 1'b0;
      else if (timer_q[cnt_w-1])
         flash_o <= ~timer_q[gate_log2_p];
   end

   assign heartbeat_o = timer_q[gate_log2_p+1];

endmodule

// File: design/led_indicator.sv
`timescale 1ns/1ns

module led_indicator import openadc_pkg::*; (
   input  logic      clk_usb,
   input  logic      reset,
   input  led_mode_t led_mode_i,
   monitor_if.indicator mon,
   input  logic      armed_i,
   input  logic      capture_i,
   input  logic      heartbeat_i,
   input  logic      flash_i,
   output logic      led_armed_o,
   output logic      led_capture_o
);

   always_ff @(posedge clk_usb) begin
      if (reset) begin
         led_armed_o <= 1'b0;
         led_capture_o <= 1'b0;
      end else if (mon.clk_changed) begin
         // changed clock wins over any mode
         led_armed_o <= flash_i;
         led_capture_o <= flash_i;
      end else begin
         case (led_mode_i)
            LED_STATUS: begin
               led_armed_o <= armed_i;
               led_capture_o <= capture_i;
            end
            LED_HEARTBEAT: begin
               led_armed_o <= heartbeat_i;
               led_capture_o <= ~heartbeat_i;
            end
            LED_EXTCLK: begin
               // dark until the first window is measured
               led_armed_o <= mon.ext_heartbeat & mon.freq_valid;
               led_capture_o <= mon.clk_changed;
            end
            default: begin  // LED_OFF
               led_armed_o <= 1'b0;
               led_capture_o <= 1'b0;
            end
         endcase
      end
   end

endmodule

// File: design/level_trigger.sv
`timescale 1ns/1ns

module level_trigger import openadc_pkg::*; (
   input  logic    clk_usb,
   input  logic    reset,
   input  sample_t adc_data_i,
   input  logic    adc_valid_i,
   input  sample_t trig_level_i,
   input  logic    arm_i,
   output logic    armed_o,
   output logic    capture_o,
   output logic    trigger_o
);

   sample_t sample_q;
   logic sample_vld_q;
   logic arm_q;
   logic allowed_q;
   logic crossed;
   logic fire;

   // payload only, qualified by sample_vld_q
   always_ff @(posedge clk_usb) begin
      if (adc_valid_i)
         sample_q <= adc_data_i;
   end

   // level msb set means trigger above, clear means below
   assign crossed = trig_level_i[$bits(sample_t)-1] ? (sample_q > trig_level_i)
                                                     : (sample_q < trig_level_i);

   // single shot, never back to back
   assign fire = allowed_q & sample_vld_q & crossed & ~trigger_o;

   always_ff @(posedge clk_usb) begin
      if (reset) begin
         sample_vld_q <= 1'b0;
         arm_q <= 1'b0;
         allowed_q <= 1'b0;
         trigger_o <= 1'b0;
         capture_o <= 1'b0;
      end else begin
         sample_vld_q <= adc_valid_i;
         arm_q <= arm_i;
         trigger_o <= fire;
         capture_o <= fire | (capture_o & arm_i);  // held until arm drops
         if (trigger_o)
            allowed_q <= 1'b0;
         else if (arm_i && !arm_q)
            allowed_q <= 1'b1;
      end
   end

   assign armed_o = allowed_q;

   a_single_cycle_trigger: assert property (
      @(posedge clk_usb) disable iff (reset)
      trigger_o |=> !trigger_o
   );

endmodule

// File: design/monitor_if.sv
`timescale 1ns/1ns

// clock monitor results towards the led logic and the top level
interface monitor_if;

   openadc_pkg::freq_t ext_freq;  // last completed window
   logic freq_valid;
   logic clk_changed;             // sticky
   logic ext_heartbeat;

   modport monitor (
      output ext_freq, freq_valid, clk_changed, ext_heartbeat
   );

   modport indicator (
      input ext_freq, freq_valid, clk_changed, ext_heartbeat
   );

endinterface

// File: design/openadc_macros.svh
`ifndef OPENADC_MACROS_SVH
`define OPENADC_MACROS_SVH

// adc sample and trigger level width
`define OADC_SAMPLE_W 12

// edges counted per gate window
`define OADC_FREQ_W 32

// pwm increment width, accumulator is one bit wider
`define OADC_GAIN_W 8

// gate period is 2**OADC_GATE_LOG2 clk_usb cycles
// roughly 87 ms at 96 MHz
`define OADC_GATE_LOG2 23

`endif

// File: design/openadc_pkg.sv
`include "openadc_macros.svh"

package openadc_pkg;

   // one adc sample, also used for the trigger level
   typedef logic [`OADC_SAMPLE_W-1:0] sample_t;

   // target clock edges per gate window
   typedef logic [`OADC_FREQ_W-1:0] freq_t;

   typedef logic [`OADC_GAIN_W-1:0] gain_t;

   // what the two front panel leds show
   typedef enum logic [1:0] {
      LED_STATUS    = 2'd0,  // armed / capture
      LED_HEARTBEAT = 2'd1,  // usb heartbeat and its inverse
      LED_EXTCLK    = 2'd2,  // ext clock heartbeat / changed flag
      LED_OFF       = 2'd3
   } led_mode_t;

endpackage

// File: design/openadc_supervisor.sv
`timescale 1ns/1ns
`include "openadc_macros.svh"

module openadc_supervisor import openadc_pkg::*; #(
   parameter int gate_log2_p = `OADC_GATE_LOG2
) (
   input  logic      clk_usb,
   input  logic      reset,
   input  sample_t   adc_data_i,
   input  logic      adc_valid_i,
   input  sample_t   trig_level_i,
   input  logic      arm_i,
   input  logic      ext_clk_i,
   input  logic      monitor_off_i,
   input  freq_t     change_limit_i,
   input  led_mode_t led_mode_i,
   input  gain_t     gain_i,
   output logic      freq_measure_o,
   output freq_t     ext_freq_o,
   output logic      clk_changed_o,
   output logic      armed_o,
   output logic      trigger_adc_o,
   output logic      led_armed_o,
   output logic      led_capture_o,
   output logic      amp_gain_o
);

   logic gate_pulse;
   logic heartbeat;
   logic flash;
   logic armed;
   logic capture;

   monitor_if mon ();

   gate_timer #(
      .gate_log2_p (gate_log2_p)
   ) u_gate_timer (
      .clk_usb      (clk_usb),
      .reset        (reset),
      .gate_pulse_o (gate_pulse),
      .heartbeat_o  (heartbeat),
      .flash_o      (flash)
   );

   clk_monitor #(
      .gate_log2_p (gate_log2_p)
   ) u_clk_monitor (
      .clk_usb        (clk_usb),
      .reset          (reset),
      .ext_clk_i      (ext_clk_i),
      .gate_pulse_i   (gate_pulse),
      .monitor_off_i  (monitor_off_i),
      .change_limit_i (change_limit_i),
      .mon            (mon.monitor)
   );

   level_trigger u_level_trigger (
      .clk_usb      (clk_usb),
      .reset        (reset),
      .adc_data_i   (adc_data_i),
      .adc_valid_i  (adc_valid_i),
      .trig_level_i (trig_level_i),
      .arm_i        (arm_i),
      .armed_o      (armed),
      .capture_o    (capture),
      .trigger_o    (trigger_adc_o)
   );

   led_indicator u_led_indicator (
      .clk_usb       (clk_usb),
      .reset         (reset),
      .led_mode_i    (led_mode_i),
      .mon           (mon.indicator),
      .armed_i       (armed),
      .capture_i     (capture),
      .heartbeat_i   (heartbeat),
      .flash_i       (flash),
      .led_armed_o   (led_armed_o),
      .led_capture_o (led_capture_o)
   );

   gain_pwm u_gain_pwm (
      .clk_usb    (clk_usb),
      .reset      (reset),
      .gain_i     (gain_i),
      .amp_gain_o (amp_gain_o)
   );

   assign freq_measure_o = gate_pulse;
   assign ext_freq_o = mon.ext_freq;
   assign clk_changed_o = mon.clk_changed;
   assign armed_o = armed;

endmodule

// File: sim/tb_openadc_util.svh
`ifndef TB_OPENADC_UTIL_SVH
`define TB_OPENADC_UTIL_SVH

// galois lfsr, x^32 + x^22 + x^2 + x + 1
function automatic logic [31:0] lfsr_next(logic [31:0] s);
   if (s[0])
      return (s >> 1) ^ 32'h80200003;
   return s >> 1;
endfunction

// one lfsr step per bit taken
function automatic logic [31:0] rnd_bits(int n);
   logic [31:0] val;
   val = '0;
   for (int k = 0; k < n; k++) begin
      lfsr_state = lfsr_next(lfsr_state);
      val = {val[30:0], lfsr_state[0]};
   end
   return val;
endfunction

task automatic check_value(string name, logic [31:0] exp, logic [31:0] act);
   if (exp !== act) begin
      err_val++;
      $display("ERR %s: expected %0d, actual %0d (cycle %0d)", name, exp, act, run_cyc);
   end
endtask

task automatic note_failure(string what);
   err_other++;
   $display("failure at cycle %0d: %s", run_cyc, what);
endtask

// level msb picks the direction
function automatic logic crosses(sample_t d, sample_t level);
   if (level[$bits(sample_t)-1])
      return d > level;
   return d < level;
endfunction

// led value after n post-reset edges, flash shown through one led register
function automatic logic flash_led(int n);
   int c;
   c = n - 2;
   return c[gate_log2+2] & ~c[gate_log2];
endfunction

// armed after edge i of a round, fire_at < 0 while no fire is known
function automatic logic armed_model(int i, int fire_at);
   if (i < 1)
      return 1'b0;
   return !(fire_at >= 0 && i >= fire_at + 1);
endfunction

`endif

// File: sim/tb_openadc_supervisor.sv
`timescale 1ns/1ns

module tb_openadc_supervisor import openadc_pkg::*; ();

   localparam int gate_log2 = 6;
   localparam int gate_len = 1 << gate_log2;
   // reset, gate, freq, change + flash, trigger rounds, led off, pwm rounds
   localparam int test_cycles = 16 + 5 * gate_len + 3 * gate_len + 2 * gate_len + 600
                                + 8 * 45 + 12 + 12 * 261;
   localparam int timeout_cycles = (test_cycles * 3 / 2 + 999) / 1000 * 1000;

   logic clk_usb = 1'b0;
   logic reset;
   sample_t adc_data_i;
   logic adc_valid_i;
   sample_t trig_level_i;
   logic arm_i;
   logic ext_clk_i = 1'b0;
   logic monitor_off_i;
   freq_t change_limit_i;
   led_mode_t led_mode_i;
   gain_t gain_i;
   logic freq_measure_o;
   freq_t ext_freq_o;
   logic clk_changed_o;
   logic armed_o;
   logic trigger_adc_o;
   logic led_armed_o;
   logic led_capture_o;
   logic amp_gain_o;

   int cyc = 0;
   int run_cyc = 0;       // edges since reset release
   int ext_period = 7;    // target clock period in clk_usb cycles
   int ext_div = 0;
   int err_val = 0;
   int err_other = 0;
   logic [31:0] lfsr_state = 32'h72cb9811;

   `include "tb_openadc_util.svh"

   openadc_supervisor #(
      .gate_log2_p (gate_log2)
   ) uut (
      .clk_usb        (clk_usb),
      .reset          (reset),
      .adc_data_i     (adc_data_i),
      .adc_valid_i    (adc_valid_i),
      .trig_level_i   (trig_level_i),
      .arm_i          (arm_i),
      .ext_clk_i      (ext_clk_i),
      .monitor_off_i  (monitor_off_i),
      .change_limit_i (change_limit_i),
      .led_mode_i     (led_mode_i),
      .gain_i         (gain_i),
      .freq_measure_o (freq_measure_o),
      .ext_freq_o     (ext_freq_o),
      .clk_changed_o  (clk_changed_o),
      .armed_o        (armed_o),
      .trigger_adc_o  (trigger_adc_o),
      .led_armed_o    (led_armed_o),
      .led_capture_o  (led_capture_o),
      .amp_gain_o     (amp_gain_o)
   );

   always #50 clk_usb = ~clk_usb;

   always @(posedge clk_usb) begin
      cyc <= cyc + 1;
      if (!reset)
         run_cyc <= run_cyc + 1;
   end

   // target clock derived from clk_usb
   always @(posedge clk_usb) begin
      ext_div <= (ext_div >= ext_period - 1) ? 0 : ext_div + 1;
      ext_clk_i <= (ext_div < ext_period / 2);
   end

   initial begin
      while (cyc < timeout_cycles)
         @(posedge clk_usb);
      $display("timeout: run did not finish within %0d cycles", timeout_cycles);
      $display("tests failed");
      $finish;
   end

   task automatic wait_gate();
      @(negedge clk_usb);
      while (!freq_measure_o)
         @(negedge clk_usb);
   endtask

   initial begin
      int i;
      int r;
      int fire_at;
      int ones;
      int t_prev;
      logic pol;
      logic v;
      sample_t level;
      sample_t d;
      gain_t g;

      reset <= 1'b1;
      adc_data_i <= '0;
      adc_valid_i <= 1'b0;
      trig_level_i <= '0;
      arm_i <= 1'b0;
      monitor_off_i <= 1'b0;
      change_limit_i <= 32'd3;
      led_mode_i <= LED_STATUS;
      gain_i <= '0;
      repeat (16) @(posedge clk_usb);
      reset <= 1'b0;

      // gate period
      wait_gate();
      t_prev = run_cyc;
      repeat (4) begin
         wait_gate();
         check_value("gate_period", gate_len, run_cyc - t_prev);
         t_prev = run_cyc;
      end

      // 700 ns target clock, count lags the gate pulse by one edge
      @(posedge clk_usb);
      monitor_off_i <= 1'b1;
      @(posedge clk_usb);
      monitor_off_i <= 1'b0;
      repeat (3) begin
         wait_gate();
         @(negedge clk_usb);
         // within one edge of gate_len / 7, scaled by 7
         if (7 * ext_freq_o < gate_len - 7 || 7 * ext_freq_o > gate_len + 7)
            note_failure($sformatf("700 ns window count %0d is more than one off %0d/7",
                                   ext_freq_o, gate_len));
      end
      check_value("no_change_700", 0, clk_changed_o);

      // 300 ns target clock
      @(posedge clk_usb);
      ext_period <= 3;
      wait_gate();
      wait_gate();
      @(negedge clk_usb);
      check_value("change_set", 1, clk_changed_o);
      @(negedge clk_usb);
      for (i = 0; i < 600; i++) begin
         check_value("flash_armed", flash_led(run_cyc), led_armed_o);
         check_value("flash_capture", flash_led(run_cyc), led_capture_o);
         @(negedge clk_usb);
      end
      @(posedge clk_usb);
      monitor_off_i <= 1'b1;
      @(posedge clk_usb);
      monitor_off_i <= 1'b0;
      @(negedge clk_usb);
      check_value("change_cleared", 0, clk_changed_o);

      // level trigger, leds in status mode
      for (r = 0; r < 8; r++) begin
         pol = rnd_bits(1) != 0;
         level = sample_t'(rnd_bits(10));
         level[11] = pol;
         level[10] = ~pol;   // keeps a crossing likely
         @(posedge clk_usb);
         trig_level_i <= level;
         fire_at = -1;
         for (i = 0; i < 40; i++) begin
            @(posedge clk_usb);
            v = rnd_bits(2) != 0;
            d = sample_t'(rnd_bits(12));
            adc_valid_i <= v;
            adc_data_i <= d;
            arm_i <= 1'b1;
            if (fire_at < 0 && v && crosses(d, level))
               fire_at = i + 2;
            @(negedge clk_usb);
            check_value("trigger", i == fire_at, trigger_adc_o);
            check_value("armed", armed_model(i, fire_at), armed_o);
            check_value("led_armed", armed_model(i - 1, fire_at), led_armed_o);
            check_value("led_capture", fire_at >= 0 && i > fire_at, led_capture_o);
         end
         if (fire_at < 0 || fire_at >= 40)
            note_failure("no crossing sample within one trigger round");
         @(posedge clk_usb);
         arm_i <= 1'b0;
         adc_valid_i <= 1'b0;
         repeat (3) @(posedge clk_usb);
      end

      @(posedge clk_usb);
      led_mode_i <= LED_OFF;
      repeat (2) @(posedge clk_usb);
      repeat (8) begin
         @(negedge clk_usb);
         check_value("led_off_armed", 0, led_armed_o);
         check_value("led_off_capture", 0, led_capture_o);
      end

      // pwm duty over a full accumulator cycle
      for (r = 0; r < 12; r++) begin
         g = (r == 0) ? 8'h00 : (r == 1) ? 8'hff : gain_t'(rnd_bits(8));
         @(posedge clk_usb);
         gain_i <= g;
         ones = 0;
         for (i = 0; i < 260; i++) begin
            @(negedge clk_usb);
            if (i >= 4)
               ones += amp_gain_o;
         end
         check_value("pwm_ones", g, ones);
      end

      $display("errors: %0d value mismatches, %0d other failures", err_val, err_other);
      if (err_val == 0 && err_other == 0) begin
         $display("all tests passed");
      end else begin
         $display("tests failed");
      end
      $finish;
   end

endmodule
